//--- meas_pkg.sv
package meas_pkg;

  ////////////////////
  // widths and constants
  ////////////////////

  // signed charge-balance count
  localparam int COUNT_W = 24;

  // run-time sample duration in clock cycles
  localparam int DUR_W = 32;

  // settle time after the input mux moves, before the adc is started
  localparam int AZ_PAD_CYCLES = 4;
  localparam int PAD_W = $clog2(AZ_PAD_CYCLES + 1);

  // typed steps so every counter moves at its own width
  localparam logic [DUR_W-1:0] DUR_ONE = 1;
  localparam logic [PAD_W-1:0] PAD_ONE = 1;
  localparam logic [PAD_W-1:0] PAD_LOAD = PAD_W'(AZ_PAD_CYCLES);
  localparam logic signed [COUNT_W-1:0] COUNT_ONE = 1;

  ////////////////////
  // state and mode encodings
  ////////////////////

  // adc phases
  typedef enum logic [1:0] {ADC_IDLE, ADC_INTEG, ADC_LATCH} adc_state_e;

  // controller phases, same set for the az and plain controllers
  typedef enum logic [1:0] {CTRL_SELECT, CTRL_PAD, CTRL_START, CTRL_WAIT} ctrl_state_e;

  // which controller owns the adc
  typedef enum logic {MODE_AZ, MODE_PLAIN} mode_e;

  // refmux switch code
  typedef enum logic [1:0] {REF_OFF = 2'b00, REF_POS = 2'b01, REF_NEG = 2'b10} ref_e;

  ////////////////////
  // result and reading
  ////////////////////

  // raw balance count, held from done until the next start
  typedef struct packed {
    logic signed [COUNT_W-1:0] count;
  } adc_result_t;

  // az set when value is hi minus lo
  typedef struct packed {
    logic                      az;
    logic signed [COUNT_W-1:0] value;
  } reading_t;

endpackage

//--- adc.sv
module adc (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [meas_pkg::DUR_W-1:0] sample_duration,
  input  logic                       adc_measure_start,
  input  logic                       cmpr,
  output meas_pkg::ref_e             refmux,
  output logic                       sigmux,
  output logic                       resetmux,
  output logic                       cmpr_latch,
  output logic                       adc_measure_done,
  output meas_pkg::adc_result_t      result
);

  meas_pkg::adc_state_e state;

  // integration cycles still to run, including the current one
  logic [meas_pkg::DUR_W-1:0] cnt;
  logic [meas_pkg::DUR_W-1:0] dur_eff;

  // running balance, +1 per high cmpr and -1 per low cmpr
  logic signed [meas_pkg::COUNT_W-1:0] count;

  logic accept;
  logic integ_last;

  // zero duration still gives a one cycle window
  assign dur_eff = (sample_duration == '0) ? meas_pkg::DUR_ONE : sample_duration;

  // start only taken once the previous result has been handed over
  assign accept = (state == meas_pkg::ADC_IDLE) && adc_measure_done && adc_measure_start;

  assign integ_last = (state == meas_pkg::ADC_INTEG) && (cnt == meas_pkg::DUR_ONE);

  ////////////////////
  // phase sequencer
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state            <= meas_pkg::ADC_IDLE;
      // done idles high so a controller can start right away
      adc_measure_done <= 1'b1;
      sigmux           <= 1'b0;
      resetmux         <= 1'b1;
      cmpr_latch       <= 1'b0;
      refmux           <= meas_pkg::REF_OFF;
    end
    else
    begin
      case (state)
        meas_pkg::ADC_IDLE:
        begin
          if (accept)
          begin
            state            <= meas_pkg::ADC_INTEG;
            adc_measure_done <= 1'b0;
            // release the integrator and connect the input together
            resetmux         <= 1'b0;
            sigmux           <= 1'b1;
          end
          else
          begin
            // result register settled one cycle ago
            adc_measure_done <= 1'b1;
          end
        end

        meas_pkg::ADC_INTEG:
        begin
          if (integ_last)
          begin
            state      <= meas_pkg::ADC_LATCH;
            sigmux     <= 1'b0;
            cmpr_latch <= 1'b1;
            refmux     <= meas_pkg::REF_OFF;
          end
          else
          begin
            // push the integrator back against the comparator
            refmux <= cmpr ? meas_pkg::REF_NEG : meas_pkg::REF_POS;
          end
        end

        meas_pkg::ADC_LATCH:
        begin
          state      <= meas_pkg::ADC_IDLE;
          cmpr_latch <= 1'b0;
          // short the integrator again while idle
          resetmux   <= 1'b1;
        end

        default:
        begin
          state <= meas_pkg::ADC_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // counter and balance count
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cnt   <= dur_eff;
      count <= '0;
    end
    else if (state == meas_pkg::ADC_INTEG)
    begin
      cnt <= cnt - meas_pkg::DUR_ONE;
      if (cmpr)
        count <= count + meas_pkg::COUNT_ONE;
      else
        count <= count - meas_pkg::COUNT_ONE;
    end

    // count is final during the latch cycle
    if (state == meas_pkg::ADC_LATCH)
      result.count <= count;
  end

endmodule

//--- az_ctrl.sv
module az_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  hold,
  input  logic                  adc_measure_done,
  input  meas_pkg::adc_result_t result,
  output logic                  adc_measure_start,
  output logic                  azmux,
  output meas_pkg::reading_t    reading,
  output logic                  reading_valid
);

  meas_pkg::ctrl_state_e state;

  logic [meas_pkg::PAD_W-1:0] pad_cnt;

  // low while taking the lo (zero) sample, high for the hi (signal) sample
  logic hi_phase;

  // done has dropped since our start, so the next high done is ours
  logic seen_low;
  logic capture;

  // lo sample kept until its hi partner arrives
  logic signed [meas_pkg::COUNT_W-1:0] lo_count;

  assign capture = (state == meas_pkg::CTRL_WAIT) && seen_low && adc_measure_done;

  ////////////////////
  // lo/hi sequencer
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state             <= meas_pkg::CTRL_SELECT;
      pad_cnt           <= '0;
      hi_phase          <= 1'b0;
      seen_low          <= 1'b0;
      azmux             <= 1'b0;
      adc_measure_start <= 1'b0;
      reading_valid     <= 1'b0;
    end
    else
    begin
      // both strobes are single cycle
      adc_measure_start <= 1'b0;
      reading_valid     <= 1'b0;

      if (hold)
      begin
        // back to the lo select with the zero input
        state    <= meas_pkg::CTRL_SELECT;
        hi_phase <= 1'b0;
        seen_low <= 1'b0;
        azmux    <= 1'b0;
      end
      else
      begin
        case (state)
          meas_pkg::CTRL_SELECT:
          begin
            azmux   <= hi_phase;
            pad_cnt <= meas_pkg::PAD_LOAD;
            state   <= meas_pkg::CTRL_PAD;
          end

          meas_pkg::CTRL_PAD:
          begin
            // let the input mux and integrator settle
            pad_cnt <= pad_cnt - meas_pkg::PAD_ONE;
            if (pad_cnt == meas_pkg::PAD_ONE)
              state <= meas_pkg::CTRL_START;
          end

          meas_pkg::CTRL_START:
          begin
            // wait for the adc to be free
            if (adc_measure_done)
            begin
              adc_measure_start <= 1'b1;
              seen_low          <= 1'b0;
              state             <= meas_pkg::CTRL_WAIT;
            end
          end

          meas_pkg::CTRL_WAIT:
          begin
            if (!adc_measure_done)
              seen_low <= 1'b1;
            if (capture)
            begin
              // a reading only leaves after the hi half
              reading_valid <= hi_phase;
              hi_phase      <= ~hi_phase;
              state         <= meas_pkg::CTRL_SELECT;
            end
          end

          default:
          begin
            state <= meas_pkg::CTRL_SELECT;
          end
        endcase
      end
    end
  end

  ////////////////////
  // lo store and difference
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (capture && !hi_phase)
      lo_count <= result.count;

    if (capture && hi_phase)
    begin
      // offset and drift cancel in hi minus lo
      reading.value <= result.count - lo_count;
      reading.az    <= 1'b1;
    end
  end

endmodule

//--- sample_ctrl.sv
module sample_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  hold,
  input  logic                  adc_measure_done,
  input  meas_pkg::adc_result_t result,
  output logic                  adc_measure_start,
  output meas_pkg::reading_t    reading,
  output logic                  reading_valid
);

  meas_pkg::ctrl_state_e state;

  logic [meas_pkg::PAD_W-1:0] pad_cnt;
  logic seen_low;
  logic capture;

  assign capture = (state == meas_pkg::CTRL_WAIT) && seen_low && adc_measure_done;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state             <= meas_pkg::CTRL_SELECT;
      pad_cnt           <= '0;
      seen_low          <= 1'b0;
      adc_measure_start <= 1'b0;
      reading_valid     <= 1'b0;
    end
    else
    begin
      adc_measure_start <= 1'b0;
      reading_valid     <= 1'b0;

      if (hold)
      begin
        state    <= meas_pkg::CTRL_SELECT;
        seen_low <= 1'b0;
      end
      else
      begin
        case (state)
          // one pad after release, the hi input is fixed from then on
          meas_pkg::CTRL_SELECT:
          begin
            pad_cnt <= meas_pkg::PAD_LOAD;
            state   <= meas_pkg::CTRL_PAD;
          end

          meas_pkg::CTRL_PAD:
          begin
            pad_cnt <= pad_cnt - meas_pkg::PAD_ONE;
            if (pad_cnt == meas_pkg::PAD_ONE)
              state <= meas_pkg::CTRL_START;
          end

          meas_pkg::CTRL_START:
          begin
            if (adc_measure_done)
            begin
              adc_measure_start <= 1'b1;
              seen_low          <= 1'b0;
              state             <= meas_pkg::CTRL_WAIT;
            end
          end

          meas_pkg::CTRL_WAIT:
          begin
            if (!adc_measure_done)
              seen_low <= 1'b1;
            if (capture)
            begin
              reading_valid <= 1'b1;
              // straight into the next sample
              state         <= meas_pkg::CTRL_START;
            end
          end

          default:
          begin
            state <= meas_pkg::CTRL_SELECT;
          end
        endcase
      end
    end
  end

  // plain count forwarded as is
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      reading.value <= result.count;
      reading.az    <= 1'b0;
    end
  end

endmodule

//--- ctrl_select.sv
module ctrl_select (
  input  logic               clk,
  input  logic               reset,
  input  meas_pkg::mode_e    mode,
  input  logic               az_start,
  input  logic               plain_start,
  input  logic               az_azmux,
  input  meas_pkg::reading_t az_reading,
  input  meas_pkg::reading_t plain_reading,
  input  logic               az_valid,
  input  logic               plain_valid,
  output logic               az_hold,
  output logic               plain_hold,
  output logic               adc_measure_start,
  output logic               azmux,
  output meas_pkg::reading_t reading,
  output logic               reading_valid
);

  meas_pkg::mode_e mode_q;
  logic changed;

  assign changed = (mode != mode_q);

  ////////////////////
  // mode register and holds
  ////////////////////

  // a change holds both controllers for a cycle, then frees the selected one
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mode_q     <= meas_pkg::MODE_AZ;
      az_hold    <= 1'b1;
      plain_hold <= 1'b1;
    end
    else
    begin
      mode_q     <= mode;
      az_hold    <= changed || (mode != meas_pkg::MODE_AZ);
      plain_hold <= changed || (mode != meas_pkg::MODE_PLAIN);
    end
  end

  // held controllers sit idle, so a plain or is enough
  assign adc_measure_start = az_start | plain_start;

  // plain controller always asks for the signal input while it runs
  assign azmux = az_azmux | ~plain_hold;

  // only the active controller's reading gets out
  always_comb
  begin
    if (mode_q == meas_pkg::MODE_AZ)
    begin
      reading       = az_reading;
      reading_valid = az_valid & ~az_hold;
    end
    else
    begin
      reading       = plain_reading;
      reading_valid = plain_valid & ~plain_hold;
    end
  end

endmodule

//--- adc_frontend.sv
module adc_frontend (
  input  logic                       clk,
  input  logic                       reset,
  input  meas_pkg::mode_e            mode,
  input  logic [meas_pkg::DUR_W-1:0] sample_duration,
  input  logic                       cmpr,
  output meas_pkg::ref_e             refmux,
  output logic                       sigmux,
  output logic                       resetmux,
  output logic                       azmux,
  output logic                       cmpr_latch,
  output meas_pkg::reading_t         reading,
  output logic                       reading_valid
);

  // adc handshake
  logic                  adc_measure_start;
  logic                  adc_measure_done;
  meas_pkg::adc_result_t result;

  // controller side of the selector
  logic               az_hold;
  logic               plain_hold;
  logic               az_start;
  logic               plain_start;
  logic               az_azmux;
  meas_pkg::reading_t az_reading;
  meas_pkg::reading_t plain_reading;
  logic               az_valid;
  logic               plain_valid;

  ////////////////////
  // integrating adc timing
  ////////////////////

  adc adc0 (
    .clk               (clk),
    .reset             (reset),
    .sample_duration   (sample_duration),
    .adc_measure_start (adc_measure_start),
    .cmpr              (cmpr),
    .refmux            (refmux),
    .sigmux            (sigmux),
    .resetmux          (resetmux),
    .cmpr_latch        (cmpr_latch),
    .adc_measure_done  (adc_measure_done),
    .result            (result)
  );

  ////////////////////
  // controllers
  ////////////////////

  az_ctrl az0 (
    .clk               (clk),
    .reset             (reset),
    .hold              (az_hold),
    .adc_measure_done  (adc_measure_done),
    .result            (result),
    .adc_measure_start (az_start),
    .azmux             (az_azmux),
    .reading           (az_reading),
    .reading_valid     (az_valid)
  );

  sample_ctrl plain0 (
    .clk               (clk),
    .reset             (reset),
    .hold              (plain_hold),
    .adc_measure_done  (adc_measure_done),
    .result            (result),
    .adc_measure_start (plain_start),
    .reading           (plain_reading),
    .reading_valid     (plain_valid)
  );

  // one controller at a time owns the adc
  ctrl_select sel0 (
    .clk               (clk),
    .reset             (reset),
    .mode              (mode),
    .az_start          (az_start),
    .plain_start       (plain_start),
    .az_azmux          (az_azmux),
    .az_reading        (az_reading),
    .plain_reading     (plain_reading),
    .az_valid          (az_valid),
    .plain_valid       (plain_valid),
    .az_hold           (az_hold),
    .plain_hold        (plain_hold),
    .adc_measure_start (adc_measure_start),
    .azmux             (azmux),
    .reading           (reading),
    .reading_valid     (reading_valid)
  );

endmodule

//--- adc_frontend_checker.sv
module adc_frontend_checker (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [63:0]                test_name,
  input  meas_pkg::mode_e            mode,
  input  logic [meas_pkg::DUR_W-1:0] sample_duration,
  input  logic                       cmpr,
  input  meas_pkg::ref_e             refmux,
  input  logic                       sigmux,
  input  logic                       resetmux,
  input  logic                       azmux,
  input  logic                       cmpr_latch,
  input  meas_pkg::reading_t         reading,
  input  logic                       reading_valid,
  output int                         reading_count,
  output int                         check_count,
  output int                         error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // values seen on the previous rising edge
  logic                       reset_q;
  logic                       sig_q;
  logic                       cmpr_q;
  logic [meas_pkg::DUR_W-1:0] dur_q;

  // window in progress
  int   win_len;
  int   win_cycles;
  int   win_count;
  logic win_hi;
  logic win_azlow;

  // finished windows split into lo and hi by azmux on the last cycle
  int   last_count;
  logic last_azlow;
  int   lo_count;
  int   hi_count;

  ////////////////////
  // reference model
  ////////////////////

  // charge balance: up on a high comparator, down on a low one
  function automatic int expect_count(input int count, input logic cmp);
    if (cmp)
      return count + 1;
    else
      return count - 1;
  endfunction

  // zero duration still integrates for one cycle
  function automatic int window_length(input logic [meas_pkg::DUR_W-1:0] dur);
    if (dur == '0)
      return 1;
    else
      return int'(dur);
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    check_count++;
    if (expected != actual)
    begin
      error_count++;
      $display("error %s: %0s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input string what, input logic ok);
    check_count++;
    if (!ok)
    begin
      error_count++;
      $display("test %s: %0s", test_name, what);
    end
  endtask

  initial
  begin
    reading_count = 0;
    check_count   = 0;
    error_count   = 0;
    lo_count      = 0;
    hi_count      = 0;
    last_count    = 0;
    last_azlow    = 1'b0;
  end

  ////////////////////
  // per-cycle checks
  ////////////////////

  always @(posedge clk)
  begin
    if (reset || reset_q)
    begin
      // adc parked and controllers quiet
      check_true("refmux not off around reset", refmux == meas_pkg::REF_OFF);
      check_true("sigmux or cmpr_latch active around reset", !sigmux && !cmpr_latch);
      check_true("integrator not shorted or input not zeroed around reset",
                 resetmux && !azmux);
      check_true("reading strobe active around reset", !reading_valid);
      sig_q = 1'b0;
    end
    else
    begin
      if (sigmux)
      begin
        // window length is fixed by the accepting edge
        if (!sig_q)
        begin
          win_count  = 0;
          win_len    = 0;
          win_azlow  = 1'b0;
          win_cycles = window_length(dur_q);
        end
        win_count = expect_count(win_count, cmpr);
        win_len++;
        win_hi = azmux;
        if (!azmux)
          win_azlow = 1'b1;
      end

      // refmux follows the comparator from the edge before
      if (sig_q && sigmux)
        check_true("refmux did not oppose the comparator",
                   refmux == (cmpr_q ? meas_pkg::REF_NEG : meas_pkg::REF_POS));

      check_true("cmpr_latch out of step with the end of integration",
                 cmpr_latch == (sig_q && !sigmux));

      // integrator released through the window and its latch cycle only
      check_true("resetmux out of step with integration",
                 resetmux == !(sigmux || sig_q));

      if (sig_q && !sigmux)
      begin
        check_value("window length", win_cycles, win_len);
        last_count = win_count;
        last_azlow = win_azlow;
        if (win_hi)
          hi_count = win_count;
        else
          lo_count = win_count;
      end

      if (reading_valid)
      begin
        reading_count++;
        if (mode == meas_pkg::MODE_AZ)
        begin
          check_true("az reading without the az flag", reading.az);
          check_value("az reading", hi_count - lo_count, int'(reading.value));
        end
        else
        begin
          check_true("plain reading with the az flag set", !reading.az);
          check_value("plain reading", last_count, int'(reading.value));
          check_true("azmux dropped during a plain sample", azmux && !last_azlow);
        end
      end
      sig_q = sigmux;
    end
    reset_q = reset;
    cmpr_q  = cmpr;
    dur_q   = sample_duration;
  end

endmodule

//--- adc_frontend_tb.sv
module adc_frontend_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF       = 20;
  localparam int NUM_TESTS      = 7;
  localparam int TIMEOUT_MARGIN = 1000;

  ////////////////////
  // test table
  ////////////////////

  localparam logic [63:0] NAMES [NUM_TESTS] = '{
    "plain_d1", "plain_d7", "plain300", "az_dur_0", "az_dur20", "az2plain", "plain2az"
  };
  localparam meas_pkg::mode_e MODES [NUM_TESTS] = '{
    meas_pkg::MODE_PLAIN, meas_pkg::MODE_PLAIN, meas_pkg::MODE_PLAIN, meas_pkg::MODE_AZ,
    meas_pkg::MODE_AZ, meas_pkg::MODE_PLAIN, meas_pkg::MODE_AZ
  };
  localparam int DURS [NUM_TESTS]   = '{1, 7, 300, 0, 20, 40, 40};
  localparam int COUNTS [NUM_TESTS] = '{4, 4, 3, 4, 4, 2, 2};
  // mode flips while the adc is integrating
  localparam logic SWITCHES [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

  logic                       clk;
  logic                       reset;
  meas_pkg::mode_e            mode;
  logic [meas_pkg::DUR_W-1:0] sample_duration;
  logic                       cmpr;
  meas_pkg::ref_e             refmux;
  logic                       sigmux;
  logic                       resetmux;
  logic                       azmux;
  logic                       cmpr_latch;
  meas_pkg::reading_t         reading;
  logic                       reading_valid;

  logic [63:0] test_name;
  int          reading_count;
  int          check_count;
  int          error_count;

  adc_frontend dut0 (
    .clk             (clk),
    .reset           (reset),
    .mode            (mode),
    .sample_duration (sample_duration),
    .cmpr            (cmpr),
    .refmux          (refmux),
    .sigmux          (sigmux),
    .resetmux        (resetmux),
    .azmux           (azmux),
    .cmpr_latch      (cmpr_latch),
    .reading         (reading),
    .reading_valid   (reading_valid)
  );

  adc_frontend_checker chk0 (
    .clk             (clk),
    .reset           (reset),
    .test_name       (test_name),
    .mode            (mode),
    .sample_duration (sample_duration),
    .cmpr            (cmpr),
    .refmux          (refmux),
    .sigmux          (sigmux),
    .resetmux        (resetmux),
    .azmux           (azmux),
    .cmpr_latch      (cmpr_latch),
    .reading         (reading),
    .reading_valid   (reading_valid),
    .reading_count   (reading_count),
    .check_count     (check_count),
    .error_count     (error_count)
  );

  always #CLK_HALF clk = ~clk;

  // two windows per reading in az mode, each window plus latch, done, pad and restart
  function automatic int timeout_cycles();
    int total;
    total = TIMEOUT_MARGIN;
    for (int t = 0; t < NUM_TESTS; t++)
      total += COUNTS[t] * 2 * ((DURS[t] == 0 ? 1 : DURS[t]) + 2 +
                                meas_pkg::AZ_PAD_CYCLES + 4);
    return total;
  endfunction

  // next rising edge of sigmux, seen on a falling edge
  task automatic wait_window_start();
    while (sigmux)
      @(negedge clk);
    while (!sigmux)
      @(negedge clk);
  endtask

  task automatic run_test(input int t);
    int base_reads;
    int base_errs;
    @(negedge clk);
    test_name       = NAMES[t];
    sample_duration = meas_pkg::DUR_W'(DURS[t]);
    if (SWITCHES[t])
    begin
      wait_window_start();
      repeat (3) @(negedge clk);
    end
    mode       = MODES[t];
    base_reads = reading_count;
    base_errs  = error_count;
    while (reading_count < base_reads + COUNTS[t])
      @(negedge clk);
    $display("test %s: %0d readings, %0d errors", NAMES[t],
             reading_count - base_reads, error_count - base_errs);
  endtask

  ////////////////////
  // comparator noise
  ////////////////////

  initial
  begin
    logic [31:0] rnd;
    void'($urandom(80));
    forever
    begin
      @(negedge clk);
      rnd  = $urandom;
      cmpr = rnd[0];
    end
  end

  initial
  begin
    int limit;
    limit = timeout_cycles();
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles waiting for readings in test %s", limit, test_name);
    $display("Checks failed");
    $finish;
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    clk             = 1'b0;
    reset           = 1'b1;
    mode            = meas_pkg::MODE_PLAIN;
    sample_duration = meas_pkg::DUR_W'(1);
    cmpr            = 1'b0;
    test_name       = "reset_st";
    repeat (2) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    $display("test %s: 0 readings, %0d errors", test_name, error_count);

    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);

    repeat (2) @(negedge clk);
    $display("%0d tests, %0d checks, %0d readings, %0d errors",
             NUM_TESTS + 1, check_count, reading_count, error_count);
    if (error_count == 0 && check_count > 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- adc_frontend.f
meas_pkg.sv
adc.sv
az_ctrl.sv
sample_ctrl.sv
ctrl_select.sv
adc_frontend.sv
adc_frontend_checker.sv
adc_frontend_tb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         := adc_frontend_tb
FLIST       := adc_frontend.f
BUILD_FLAGS := --binary --timing -j 0
LINT_FLAGS  := --lint-only -Wall --timing
OBJ_DIR     := obj_dir
SIM         := $(OBJ_DIR)/V$(TOP)
LOG         := sim.log
PASS_MSG    := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: build
	./$(SIM) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
